// ==== rtl/lane_cfg_pkg.sv ====
package lane_cfg_pkg;

   // Storage geometry
   localparam int DATA_W    = 32;
   localparam int NUM_BYTES = 4;
   localparam int VRF_DEPTH = 64;
   localparam int REG_AW    = 6;
   localparam int WB_AW     = 8;

   // Region field sits in address bits 7..6
   localparam logic [1:0] REGION_VRF   = 2'd0;
   localparam logic [1:0] REGION_MASK  = 2'd1;
   localparam logic [1:0] REGION_ISSUE = 2'd2;

   //////////////////////////////////////////////////
   // Wishbone classic and host write request
   //////////////////////////////////////////////////
   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [WB_AW-1:0]  adr;
      logic [DATA_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic              ack;
      logic [DATA_W-1:0] dat;
   } wb_rsp_t;

   typedef struct packed {
      logic              valid;
      logic              is_mask;
      logic [REG_AW-1:0] idx;
      logic [DATA_W-1:0] data;
   } host_wr_t;

endpackage

// ==== rtl/lane_isa_pkg.sv ====
package lane_isa_pkg;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   // Code 3 behaves as a word
   typedef enum logic [1:0] {
      SEW_BYTE = 2'd0,
      SEW_HALF = 2'd1,
      SEW_WORD = 2'd2
   } sew_e;

   localparam int CMD_W = 28;

   // Command word, first field is the top of the word
   typedef struct packed {
      logic [lane_cfg_pkg::REG_AW-1:0] vs2;
      logic [lane_cfg_pkg::REG_AW-1:0] vs1;
      logic [lane_cfg_pkg::REG_AW-1:0] vd;
      logic [1:0]                      vs2_idx;
      logic [1:0]                      vs1_idx;
      logic                            masked;
      sew_e                            sew;
      alu_op_e                         opcode;
   } lane_cmd_t;

   //////////////////////////////////////////////////
   // Stage payloads
   //////////////////////////////////////////////////
   typedef struct packed {
      logic                            valid;
      alu_op_e                         opcode;
      sew_e                            sew;
      logic                            masked;
      logic [lane_cfg_pkg::REG_AW-1:0] vd;
      logic [lane_cfg_pkg::DATA_W-1:0] op_a;
      logic [lane_cfg_pkg::DATA_W-1:0] op_b;
   } op_stage_t;

   typedef struct packed {
      logic                            valid;
      sew_e                            sew;
      logic                            masked;
      logic [lane_cfg_pkg::REG_AW-1:0] vd;
      logic [lane_cfg_pkg::DATA_W-1:0] result;
   } wb_stage_t;

endpackage

// ==== rtl/lane_regfile.sv ====
`timescale 1ns/1ps

module lane_regfile #(
   parameter type entry_t = logic [7:0],
   parameter int  DEPTH   = 64,
   parameter int  NUM_RD  = 2
) (
   input  logic                                  clk_i,
   input  logic                                  rst_i,
   input  logic                                  we_i,
   input  logic [$clog2(DEPTH)-1:0]              waddr_i,
   input  entry_t                                wdata_i,
   input  logic [NUM_RD-1:0][$clog2(DEPTH)-1:0]  raddr_i,
   output entry_t [NUM_RD-1:0]                   rdata_o
);

   entry_t mem_q [DEPTH];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] <= '0;
         end
      end else if (we_i) begin
         mem_q[waddr_i] <= wdata_i;
      end
   end

   // Reads see the array directly, no output register
   always_comb begin
      for (int r = 0; r < NUM_RD; r++) begin
         rdata_o[r] = mem_q[raddr_i[r]];
      end
   end

endmodule

// ==== rtl/lane_wb_slave.sv ====
`timescale 1ns/1ps

module lane_wb_slave (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  lane_cfg_pkg::wb_req_t              wb_i,
   output lane_cfg_pkg::wb_rsp_t              wb_o,
   output lane_cfg_pkg::host_wr_t             host_wr_o,
   input  logic                               host_gnt_i,
   output logic [lane_cfg_pkg::REG_AW-1:0]    host_raddr_o,
   input  logic [lane_cfg_pkg::DATA_W-1:0]    host_vrf_rdata_i,
   input  logic                               host_mask_rdata_i,
   output lane_isa_pkg::lane_cmd_t            issue_o,
   output logic                               issue_vld_o
);

   import lane_cfg_pkg::*;
   import lane_isa_pkg::*;

   logic [1:0]        region;
   logic              req;
   logic              reg_wr;
   logic              issue_wr;
   logic [DATA_W-1:0] rd_word;

   logic              ack_q;
   logic [DATA_W-1:0] rdata_q;
   logic              hw_vld_q;
   logic              hw_mask_q;
   logic [REG_AW-1:0] hw_idx_q;
   logic [DATA_W-1:0] hw_data_q;
   lane_cmd_t         issue_q;
   logic              issue_vld_q;

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////
   assign region       = wb_i.adr[WB_AW-1 -: 2];
   assign host_raddr_o = wb_i.adr[REG_AW-1:0];

   // New transfer only when nothing is acked or waiting for a grant
   assign req      = wb_i.cyc & wb_i.stb & ~ack_q & ~hw_vld_q;
   assign reg_wr   = wb_i.we & ((region == REGION_VRF) | (region == REGION_MASK));
   assign issue_wr = wb_i.we & (region == REGION_ISSUE);

   always_comb begin
      case (region)
         REGION_VRF:  rd_word = host_vrf_rdata_i;
         REGION_MASK: rd_word = {{(DATA_W-1){1'b0}}, host_mask_rdata_i};
         default:     rd_word = '0;
      endcase
   end

   //////////////////////////////////////////////////
   // Ack, pending host write, issue valid
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ack_q       <= 1'b0;
         hw_vld_q    <= 1'b0;
         issue_vld_q <= 1'b0;
      end else begin
         // Register writes wait for the writeback grant
         ack_q       <= (req & ~reg_wr) | (hw_vld_q & host_gnt_i);
         issue_vld_q <= req & issue_wr;
         if (req & reg_wr) begin
            hw_vld_q <= 1'b1;
         end else if (host_gnt_i) begin
            hw_vld_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req) begin
         rdata_q   <= wb_i.we ? '0 : rd_word;
         hw_mask_q <= (region == REGION_MASK);
         hw_idx_q  <= wb_i.adr[REG_AW-1:0];
         hw_data_q <= wb_i.dat;
      end
      if (req & issue_wr) begin
         issue_q <= lane_cmd_t'(wb_i.dat[CMD_W-1:0]);
      end
   end

   assign wb_o.ack = ack_q;
   assign wb_o.dat = rdata_q;

   assign host_wr_o.valid   = hw_vld_q;
   assign host_wr_o.is_mask = hw_mask_q;
   assign host_wr_o.idx     = hw_idx_q;
   assign host_wr_o.data    = hw_data_q;

   assign issue_o     = issue_q;
   assign issue_vld_o = issue_vld_q;

endmodule

// ==== rtl/lane_operand_stage.sv ====
`timescale 1ns/1ps

module lane_operand_stage (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  lane_isa_pkg::lane_cmd_t            issue_i,
   input  logic                               issue_vld_i,
   output logic [lane_cfg_pkg::REG_AW-1:0]    vs1_addr_o,
   output logic [lane_cfg_pkg::REG_AW-1:0]    vs2_addr_o,
   input  logic [lane_cfg_pkg::DATA_W-1:0]    vs1_word_i,
   input  logic [lane_cfg_pkg::DATA_W-1:0]    vs2_word_i,
   output lane_isa_pkg::op_stage_t            op_o
);

   import lane_cfg_pkg::*;
   import lane_isa_pkg::*;

   op_stage_t op_d;
   op_stage_t op_q;

   // Pick one element out of a word and zero-extend it
   function automatic logic [DATA_W-1:0] extract(logic [DATA_W-1:0] word, sew_e sew,
                                                 logic [1:0] idx);
      case (sew)
         SEW_BYTE: return {{(DATA_W-8){1'b0}}, word[idx*8 +: 8]};
         SEW_HALF: return {{(DATA_W-16){1'b0}}, word[idx[0]*16 +: 16]};
         default:  return word;
      endcase
   endfunction

   assign vs1_addr_o = issue_i.vs1;
   assign vs2_addr_o = issue_i.vs2;

   always_comb begin
      op_d.valid  = issue_vld_i;
      op_d.opcode = issue_i.opcode;
      op_d.sew    = issue_i.sew;
      op_d.masked = issue_i.masked;
      op_d.vd     = issue_i.vd;
      op_d.op_a   = extract(vs1_word_i, issue_i.sew, issue_i.vs1_idx);
      op_d.op_b   = extract(vs2_word_i, issue_i.sew, issue_i.vs2_idx);
   end

   // Operand register
   always_ff @(posedge clk_i) begin
      op_q <= op_d;
      if (!rst_i) begin
         op_q.valid <= 1'b0;
      end
   end

   assign op_o = op_q;

endmodule

// ==== rtl/lane_alu_stage.sv ====
`timescale 1ns/1ps

module lane_alu_stage (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  lane_isa_pkg::op_stage_t op_i,
   output lane_isa_pkg::wb_stage_t res_o
);

   import lane_cfg_pkg::*;
   import lane_isa_pkg::*;

   wb_stage_t         res_d;
   wb_stage_t         res_q;
   logic [DATA_W-1:0] alu_out;

   // op_a comes from vs1, op_b from vs2
   always_comb begin
      case (op_i.opcode)
         ALU_ADD: alu_out = op_i.op_a + op_i.op_b;
         ALU_SUB: alu_out = op_i.op_a - op_i.op_b;
         ALU_AND: alu_out = op_i.op_a & op_i.op_b;
         ALU_OR:  alu_out = op_i.op_a | op_i.op_b;
         ALU_XOR: alu_out = op_i.op_a ^ op_i.op_b;
         default: alu_out = '0;
      endcase
   end

   always_comb begin
      res_d.valid  = op_i.valid;
      res_d.sew    = op_i.sew;
      res_d.masked = op_i.masked;
      res_d.vd     = op_i.vd;
      res_d.result = alu_out;
   end

   always_ff @(posedge clk_i) begin
      res_q <= res_d;
      if (!rst_i) begin
         res_q.valid <= 1'b0;
      end
   end

   assign res_o = res_q;

endmodule

// ==== rtl/lane_writeback.sv ====
`timescale 1ns/1ps

module lane_writeback (
   input  logic                                clk_i,
   input  logic                                rst_i,
   input  lane_isa_pkg::wb_stage_t             res_i,
   input  lane_cfg_pkg::host_wr_t              host_wr_i,
   output logic                                host_gnt_o,
   output logic [lane_cfg_pkg::REG_AW-1:0]     mask_raddr_o,
   input  logic                                mask_bit_i,
   output logic [lane_cfg_pkg::NUM_BYTES-1:0]  vrf_we_o,
   output logic [lane_cfg_pkg::REG_AW-1:0]     vrf_waddr_o,
   output logic [lane_cfg_pkg::DATA_W-1:0]     vrf_wdata_o,
   output logic                                mask_we_o,
   output logic [lane_cfg_pkg::REG_AW-1:0]     mask_waddr_o,
   output logic                                mask_wdata_o
);

   import lane_cfg_pkg::*;
   import lane_isa_pkg::*;

   logic [NUM_BYTES-1:0] lane_en;
   logic                 pipe_wr;
   logic                 host_take;
   logic                 gnt_q;

   assign mask_raddr_o = res_i.vd;

   // Element width sets the low lanes written
   always_comb begin
      case (res_i.sew)
         SEW_BYTE: lane_en = NUM_BYTES'(1);
         SEW_HALF: lane_en = NUM_BYTES'(3);
         default:  lane_en = '1;
      endcase
   end

   assign pipe_wr = res_i.valid & (~res_i.masked | mask_bit_i);

   // Host slot is any cycle without a pipeline result
   assign host_take = host_wr_i.valid & ~res_i.valid & ~gnt_q;

   //////////////////////////////////////////////////
   // Write port mux
   //////////////////////////////////////////////////
   always_comb begin
      if (res_i.valid) begin
         vrf_we_o    = pipe_wr ? lane_en : '0;
         vrf_waddr_o = res_i.vd;
         vrf_wdata_o = res_i.result;
      end else begin
         vrf_we_o    = {NUM_BYTES{host_take & ~host_wr_i.is_mask}};
         vrf_waddr_o = host_wr_i.idx;
         vrf_wdata_o = host_wr_i.data;
      end
   end

   assign mask_we_o    = host_take & host_wr_i.is_mask;
   assign mask_waddr_o = host_wr_i.idx;
   assign mask_wdata_o = host_wr_i.data[0];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         gnt_q <= 1'b0;
      end else begin
         gnt_q <= host_take;
      end
   end

   assign host_gnt_o = gnt_q;

endmodule

// ==== rtl/lane_top.sv ====
`timescale 1ns/1ps

module lane_top (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  lane_cfg_pkg::wb_req_t wb_i,
   output lane_cfg_pkg::wb_rsp_t wb_o,
   output logic                  busy_o
);

   import lane_cfg_pkg::*;
   import lane_isa_pkg::*;

   host_wr_t             host_wr;
   logic                 host_gnt;
   logic [REG_AW-1:0]    host_raddr;
   logic [DATA_W-1:0]    host_vrf_rdata;
   logic                 host_mask_rdata;
   lane_cmd_t            issue;
   logic                 issue_vld;

   logic [REG_AW-1:0]    vs1_addr;
   logic [REG_AW-1:0]    vs2_addr;
   logic [DATA_W-1:0]    vs1_word;
   logic [DATA_W-1:0]    vs2_word;
   op_stage_t            op;
   wb_stage_t            res;

   logic [REG_AW-1:0]    mask_raddr;
   logic                 mask_bit;
   logic [NUM_BYTES-1:0] vrf_we;
   logic [REG_AW-1:0]    vrf_waddr;
   logic [DATA_W-1:0]    vrf_wdata;
   logic                 mask_we;
   logic [REG_AW-1:0]    mask_waddr;
   logic                 mask_wdata;

   // Read ports are vs1, vs2, host
   logic [2:0][REG_AW-1:0]          vrf_raddr;
   logic [NUM_BYTES-1:0][2:0][7:0]  vrf_rdata;

   lane_wb_slave wb_slave_i (
      .clk_i             (clk_i),
      .rst_i             (rst_i),
      .wb_i              (wb_i),
      .wb_o              (wb_o),
      .host_wr_o         (host_wr),
      .host_gnt_i        (host_gnt),
      .host_raddr_o      (host_raddr),
      .host_vrf_rdata_i  (host_vrf_rdata),
      .host_mask_rdata_i (host_mask_rdata),
      .issue_o           (issue),
      .issue_vld_o       (issue_vld)
   );

   lane_operand_stage operand_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .issue_i     (issue),
      .issue_vld_i (issue_vld),
      .vs1_addr_o  (vs1_addr),
      .vs2_addr_o  (vs2_addr),
      .vs1_word_i  (vs1_word),
      .vs2_word_i  (vs2_word),
      .op_o        (op)
   );

   lane_alu_stage alu_i (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .op_i  (op),
      .res_o (res)
   );

   lane_writeback writeback_i (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .res_i        (res),
      .host_wr_i    (host_wr),
      .host_gnt_o   (host_gnt),
      .mask_raddr_o (mask_raddr),
      .mask_bit_i   (mask_bit),
      .vrf_we_o     (vrf_we),
      .vrf_waddr_o  (vrf_waddr),
      .vrf_wdata_o  (vrf_wdata),
      .mask_we_o    (mask_we),
      .mask_waddr_o (mask_waddr),
      .mask_wdata_o (mask_wdata)
   );

   //////////////////////////////////////////////////
   // VRF byte lanes and mask file
   //////////////////////////////////////////////////
   assign vrf_raddr = {host_raddr, vs2_addr, vs1_addr};

   for (genvar b = 0; b < NUM_BYTES; b++) begin : g_vrf
      lane_regfile #(
         .entry_t (logic [7:0]),
         .DEPTH   (VRF_DEPTH),
         .NUM_RD  (3)
      ) vrf_lane_i (
         .clk_i   (clk_i),
         .rst_i   (rst_i),
         .we_i    (vrf_we[b]),
         .waddr_i (vrf_waddr),
         .wdata_i (vrf_wdata[b*8 +: 8]),
         .raddr_i (vrf_raddr),
         .rdata_o (vrf_rdata[b])
      );

      assign vs1_word[b*8 +: 8]       = vrf_rdata[b][0];
      assign vs2_word[b*8 +: 8]       = vrf_rdata[b][1];
      assign host_vrf_rdata[b*8 +: 8] = vrf_rdata[b][2];
   end

   lane_regfile #(
      .entry_t (logic),
      .DEPTH   (VRF_DEPTH),
      .NUM_RD  (2)
   ) mask_file_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .we_i    (mask_we),
      .waddr_i (mask_waddr),
      .wdata_i (mask_wdata),
      .raddr_i ({host_raddr, mask_raddr}),
      .rdata_o ({host_mask_rdata, mask_bit})
   );

   assign busy_o = issue_vld | op.valid | res.valid;

endmodule

// ==== bench/lane_tb_model.svh ====
`ifndef LANE_TB_MODEL_SVH
`define LANE_TB_MODEL_SVH

// Zero-extended element k of a source word
function automatic logic [31:0] extract_elem(input logic [31:0] word, input logic [1:0] sew,
                                             input logic [1:0] idx);
   logic [31:0] shifted;
   if (sew == 2'd0) begin
      shifted = word >> (8 * idx);
      return shifted & 32'h0000_00ff;
   end
   if (sew == 2'd1) begin
      shifted = word >> (16 * idx[0]);
      return shifted & 32'h0000_ffff;
   end
   return word;
endfunction

// Five ALU functions, unused codes give zero
function automatic logic [31:0] alu_result(input logic [2:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
   case (op)
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      default: return 32'h0;
   endcase
endfunction

// New vd after writeback of the low lanes
function automatic logic [31:0] merge_write(input logic [31:0] old, input logic [31:0] res,
                                            input logic [1:0] sew, input logic masked,
                                            input logic mbit);
   logic [31:0] keep;
   if (masked && !mbit) begin
      return old;
   end
   case (sew)
      2'd0:    keep = 32'hffff_ff00;
      2'd1:    keep = 32'hffff_0000;
      default: keep = 32'h0000_0000;
   endcase
   return (old & keep) | (res & ~keep);
endfunction

`endif

// ==== bench/lane_tb.sv ====
`timescale 1ns/1ps

module lane_tb;

   import lane_cfg_pkg::*;
   import lane_isa_pkg::*;

   `include "lane_tb_model.svh"

   localparam int XFER_LIMIT  = 20;
   // Fill and readback, opcodes, element widths, masking, burst
   localparam int N_XFER      = 4 * VRF_DEPTH + 16 + 12 + 9 + 12;
   localparam int CYCLE_LIMIT = N_XFER * 30 + 100;

   logic    clk_i;
   logic    rst_i;
   wb_req_t wb_req;
   wb_rsp_t wb_rsp;
   logic    busy;

   logic [31:0] vrf_sh [VRF_DEPTH];
   logic        mask_sh [VRF_DEPTH];
   logic [31:0] rng;
   int          val_err;
   int          proto_err;
   int          check_cnt;
   int          cycle_cnt = 0;

   // Readback results waiting for the comparing process
   logic [31:0]      exp_q [$];
   logic [31:0]      got_q [$];
   logic [WB_AW-1:0] adr_q [$];
   logic [31:0]      got_v;
   logic [31:0]      exp_v;
   logic [WB_AW-1:0] adr_v;

   lane_top lane_top_i (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .wb_i   (wb_req),
      .wb_o   (wb_rsp),
      .busy_o (busy)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic lane_cmd_t make_cmd(input logic [2:0] op, input logic [1:0] sew,
                                          input logic masked, input logic [1:0] i1,
                                          input logic [1:0] i2, input logic [5:0] vd,
                                          input logic [5:0] vs1, input logic [5:0] vs2);
      lane_cmd_t c;
      c.opcode  = alu_op_e'(op);
      c.sew     = sew_e'(sew);
      c.masked  = masked;
      c.vs1_idx = i1;
      c.vs2_idx = i2;
      c.vd      = vd;
      c.vs1     = vs1;
      c.vs2     = vs2;
      return c;
   endfunction

   //////////////////////////////////////////////////
   // Wishbone master
   //////////////////////////////////////////////////
   task automatic wb_xfer(input logic we, input logic [WB_AW-1:0] adr, input logic [31:0] dat,
                          output logic [31:0] rdata, output int waited);
      int n;
      @(negedge clk_i);
      // Ack of the previous transfer must be gone by now
      if (wb_rsp.ack) begin
         proto_err++;
         $display("ack still high at the start of a transfer to address %h", adr);
      end
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = dat;
      n = 0;
      do begin
         @(negedge clk_i);
         n++;
      end while (!wb_rsp.ack && n < XFER_LIMIT);
      if (!wb_rsp.ack) begin
         proto_err++;
         $display("no ack within %0d cycles for a transfer to address %h", XFER_LIMIT, adr);
      end
      rdata      = wb_rsp.dat;
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      wb_req.we  = 1'b0;
      waited     = n;
   endtask

   task automatic write_word(input logic [WB_AW-1:0] adr, input logic [31:0] dat);
      logic [31:0] rdata;
      int          waited;
      wb_xfer(1'b1, adr, dat, rdata, waited);
   endtask

   task automatic read_check(input logic [WB_AW-1:0] adr, input logic [31:0] expected);
      logic [31:0] rdata;
      int          waited;
      wb_xfer(1'b0, adr, 32'h0, rdata, waited);
      got_q.push_back(rdata);
      exp_q.push_back(expected);
      adr_q.push_back(adr);
   endtask

   // Updates the shadow VRF, then issues the command
   task automatic issue_op(input lane_cmd_t cmd, input bit idle);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] rdata;
      int          waited;
      a = extract_elem(vrf_sh[cmd.vs1], cmd.sew, cmd.vs1_idx);
      b = extract_elem(vrf_sh[cmd.vs2], cmd.sew, cmd.vs2_idx);
      r = alu_result(cmd.opcode, a, b);
      vrf_sh[cmd.vd] = merge_write(vrf_sh[cmd.vd], r, cmd.sew, cmd.masked, mask_sh[cmd.vd]);
      wb_xfer(1'b1, {REGION_ISSUE, 6'd0}, 32'(cmd), rdata, waited);
      if (idle && waited != 1) begin
         proto_err++;
         $display("issue ack came %0d cycles after stb instead of 1", waited);
      end
      if (!busy) begin
         proto_err++;
         $display("busy_o low while an issued command is in the pipeline");
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < 50) begin
         @(negedge clk_i);
         n++;
      end
      if (busy) begin
         proto_err++;
         $display("busy_o never fell after the last issue");
      end else if (n > 4) begin
         proto_err++;
         $display("busy_o fell %0d cycles after the last ack, more than 4", n);
      end
   endtask

   //////////////////////////////////////////////////
   // Comparison and run limit
   //////////////////////////////////////////////////
   always @(posedge clk_i) begin
      while (got_q.size() != 0) begin
         got_v = got_q.pop_front();
         exp_v = exp_q.pop_front();
         adr_v = adr_q.pop_front();
         check_cnt++;
         if (got_v !== exp_v) begin
            val_err++;
            $display("Fail wb_o.dat at address %h: got %h, expected %h", adr_v, got_v, exp_v);
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("sim failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] d;
      lane_cmd_t   cmd;
      rst_i     = 1'b0;
      wb_req    = '0;
      rng       = 32'd10;
      val_err   = 0;
      proto_err = 0;
      check_cnt = 0;
      for (int i = 0; i < VRF_DEPTH; i++) begin
         vrf_sh[i]  = 32'h0;
         mask_sh[i] = 1'b0;
      end
      repeat (8) @(negedge clk_i);
      rst_i = 1'b1;
      if (wb_rsp.ack || busy) begin
         proto_err++;
         $display("ack or busy_o high right after reset");
      end

      // Host fill of every word and mask bit, then readback
      for (int i = 0; i < VRF_DEPTH; i++) begin
         d = next_rand();
         vrf_sh[i] = d;
         write_word({REGION_VRF, 6'(i)}, d);
      end
      for (int i = 0; i < VRF_DEPTH; i++) begin
         read_check({REGION_VRF, 6'(i)}, vrf_sh[i]);
      end
      for (int i = 0; i < VRF_DEPTH; i++) begin
         d = next_rand();
         mask_sh[i] = d[0];
         write_word({REGION_MASK, 6'(i)}, d);
      end
      for (int i = 0; i < VRF_DEPTH; i++) begin
         read_check({REGION_MASK, 6'(i)}, {31'b0, mask_sh[i]});
      end

      // All eight opcodes at word width
      for (int op = 0; op < 8; op++) begin
         d   = next_rand();
         cmd = make_cmd(3'(op), 2'd2, 1'b0, 2'd0, 2'd0, 6'(48 + op), {1'b0, d[4:0]},
                        {1'b0, d[12:8]});
         issue_op(cmd, 1'b1);
         wait_idle();
         read_check({REGION_VRF, cmd.vd}, vrf_sh[cmd.vd]);
      end

      // Bytes at index 0..3, halves at index 0..1
      for (int n = 0; n < 6; n++) begin
         d   = next_rand();
         cmd = make_cmd(3'(n % 5), (n < 4) ? 2'd0 : 2'd1, 1'b0,
                        (n < 4) ? 2'(n) : 2'(n - 4), (n < 4) ? 2'(3 - n) : 2'(5 - n),
                        6'(40 + n), {1'b0, d[4:0]}, {1'b0, d[12:8]});
         issue_op(cmd, 1'b1);
         wait_idle();
         read_check({REGION_VRF, cmd.vd}, vrf_sh[cmd.vd]);
      end

      // Mask bits 1, 0, 0 for two masked ops and one unmasked
      mask_sh[50] = 1'b1;
      mask_sh[51] = 1'b0;
      mask_sh[52] = 1'b0;
      write_word({REGION_MASK, 6'd50}, 32'h1);
      write_word({REGION_MASK, 6'd51}, 32'h0);
      write_word({REGION_MASK, 6'd52}, 32'h0);
      for (int n = 0; n < 3; n++) begin
         d   = next_rand();
         cmd = make_cmd(3'd4, 2'd2, (n < 2), 2'd0, 2'd0, 6'(50 + n), {1'b0, d[4:0]},
                        {1'b0, d[12:8]});
         issue_op(cmd, 1'b1);
         wait_idle();
         read_check({REGION_VRF, cmd.vd}, vrf_sh[cmd.vd]);
      end

      // Burst of six, sources never written inside the burst
      for (int n = 0; n < 6; n++) begin
         d   = next_rand();
         cmd = make_cmd(3'(d[18:16] % 5), d[21:20], d[22], d[24:23], d[26:25], 6'(32 + n),
                        {1'b0, d[4:0]}, {1'b0, d[12:8]});
         issue_op(cmd, n == 0);
      end
      wait_idle();
      for (int n = 0; n < 6; n++) begin
         read_check({REGION_VRF, 6'(32 + n)}, vrf_sh[32 + n]);
      end

      while (got_q.size() != 0) begin
         @(negedge clk_i);
      end
      @(negedge clk_i);
      $display("checks %0d, value errors %0d, protocol errors %0d", check_cnt, val_err,
               proto_err);
      if (val_err == 0 && proto_err == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+bench
rtl/lane_cfg_pkg.sv
rtl/lane_isa_pkg.sv
rtl/lane_regfile.sv
rtl/lane_wb_slave.sv
rtl/lane_operand_stage.sv
rtl/lane_alu_stage.sv
rtl/lane_writeback.sv
rtl/lane_top.sv
bench/lane_tb.sv

// ==== Bender.yml ====
package:
  name: vector_lane

sources:
  - files:
      - rtl/lane_cfg_pkg.sv
      - rtl/lane_isa_pkg.sv
      - rtl/lane_regfile.sv
      - rtl/lane_wb_slave.sv
      - rtl/lane_operand_stage.sv
      - rtl/lane_alu_stage.sv
      - rtl/lane_writeback.sv
      - rtl/lane_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lane_tb.sv
